//--- vga_pkg.sv
// Shared types and constants of the VGA tile game renderer
// 640x480 at 60 Hz timing, tile geometry, colour keys and motion states

`default_nettype none

package vga_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [11:0] rgb_t;
	typedef logic [9:0]  coord_t;
	typedef logic [9:0]  img_addr_t;
	typedef logic [2:0]  tile_code_t;
	typedef logic [1:0]  img_sel_t;

	typedef enum logic [1:0] {
		MOVE_STOP,
		MOVE_DOWN,
		MOVE_UP
	} move_state_t;

	// Image select codes on the load port and for the sprite frame
	localparam img_sel_t IMG_FRONT = 2'd0;
	localparam img_sel_t IMG_UP0   = 2'd1;
	localparam img_sel_t IMG_UP1   = 2'd2;
	localparam img_sel_t IMG_ATLAS = 2'd3;

	////////////////////////////////////////////////////////////////////////////
	// Display timing, syncs active low
	////////////////////////////////////////////////////////////////////////////

	localparam int H_DISPLAY = 640;
	localparam int H_FRONT   = 16;
	localparam int H_SYNC    = 96;
	localparam int H_TOTAL   = 800;
	localparam int V_DISPLAY = 480;
	localparam int V_FRONT   = 10;
	localparam int V_SYNC    = 2;
	localparam int V_TOTAL   = 525;

	////////////////////////////////////////////////////////////////////////////
	// Tiles and sprite
	////////////////////////////////////////////////////////////////////////////

	localparam int MAP_COLS    = 20;
	localparam int MAP_ROWS    = 10;
	localparam int TILE_SIZE   = 16;
	localparam int SPRITE_SIZE = 16;
	// Size on screen after doubling
	localparam int SPRITE_LEN  = 32;

	localparam rgb_t TRANSPARENT_KEY = 12'hCBE;
	localparam int PLAYER_ROW_INIT   = 300;
	localparam int PLAYER_COL_INIT   = 300;

endpackage

`default_nettype wire

//--- vga_timing_if.sv
// Pixel position and raw syncs from the timing generator to the renderer

`timescale 1ns/1ps
`default_nettype none

interface vga_timing_if;

	// Both positions read zero while blanking
	vga_pkg::coord_t h_pos;
	vga_pkg::coord_t v_pos;
	logic            active;
	logic            hsync_raw;
	logic            vsync_raw;

	modport source (
		output h_pos,
		output v_pos,
		output active,
		output hsync_raw,
		output vsync_raw
	);

	modport sink (
		input h_pos,
		input v_pos,
		input active,
		input hsync_raw,
		input vsync_raw
	);

endinterface

`default_nettype wire

//--- vga_timing.sv
// VGA timing generator for 640x480
// Free running pixel and line counters with registered active low syncs

`timescale 1ns/1ps
`default_nettype none

module vga_timing (
	input  logic         clk,
	input  logic         rst,
	vga_timing_if.source tim
);

	localparam int H_SYNC_START = vga_pkg::H_DISPLAY + vga_pkg::H_FRONT;
	localparam int H_SYNC_END   = H_SYNC_START + vga_pkg::H_SYNC;
	localparam int V_SYNC_START = vga_pkg::V_DISPLAY + vga_pkg::V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + vga_pkg::V_SYNC;

	vga_pkg::coord_t pixel_cnt;
	vga_pkg::coord_t line_cnt;
	logic            line_end;
	logic            h_in_sync;
	logic            v_in_sync;
	logic            hsync_q;
	logic            vsync_q;
	logic            active;

	assign line_end = (int'(pixel_cnt) == vga_pkg::H_TOTAL - 1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pixel_cnt <= '0;
			line_cnt  <= '0;
		end else if (line_end) begin
			pixel_cnt <= '0;
			if (int'(line_cnt) == vga_pkg::V_TOTAL - 1)
				line_cnt <= '0;
			else
				line_cnt <= line_cnt + 1'b1;
		end else begin
			pixel_cnt <= pixel_cnt + 1'b1;
		end
	end

	// Sync pulses lag the count by one register
	assign h_in_sync = (int'(pixel_cnt) >= H_SYNC_START) && (int'(pixel_cnt) < H_SYNC_END);
	assign v_in_sync = (int'(line_cnt) >= V_SYNC_START) && (int'(line_cnt) < V_SYNC_END);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
		end else begin
			hsync_q <= ~h_in_sync;
			vsync_q <= ~v_in_sync;
		end
	end

	assign active = (int'(pixel_cnt) < vga_pkg::H_DISPLAY) &&
	                (int'(line_cnt) < vga_pkg::V_DISPLAY);

	assign tim.active    = active;
	assign tim.h_pos     = active ? pixel_cnt : '0;
	assign tim.v_pos     = active ? line_cnt : '0;
	assign tim.hsync_raw = hsync_q;
	assign tim.vsync_raw = vsync_q;

endmodule

`default_nettype wire

//--- button_input.sv
// Button front end
// Slow tick generator and five-sample debouncers for the up and down buttons

`timescale 1ns/1ps
`default_nettype none

module button_input #(
	parameter int TICK_LOG2 = 13
) (
	input  logic clk,
	input  logic rst,
	input  logic btn_up_i,
	input  logic btn_down_i,
	output logic tick_o,
	output logic up_o,
	output logic down_o
);

	logic [TICK_LOG2-1:0] div_cnt;
	logic [1:0]           btn_raw;
	logic [1:0][4:0]      shift_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// One cycle pulse as the divider wraps
	assign tick_o = &div_cnt;

	// Index 0 is up, index 1 is down
	assign btn_raw = {btn_down_i, btn_up_i};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			shift_q <= '0;
		end else if (tick_o) begin
			for (int i = 0; i < 2; i++)
				shift_q[i] <= {shift_q[i][3:0], btn_raw[i]};
		end
	end

	// Pressed once five samples in a row are high
	assign up_o   = &shift_q[0];
	assign down_o = &shift_q[1];

endmodule

`default_nettype wire

//--- player_motion.sv
// Player motion
// Step FSM that walks the sprite 32 rows per press and picks the walking frame

`timescale 1ns/1ps
`default_nettype none

module player_motion #(
	parameter int WALK_DELAY = 6
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              tick_i,
	input  logic              up_i,
	input  logic              down_i,
	output vga_pkg::coord_t   row_o,
	output vga_pkg::coord_t   col_o,
	output vga_pkg::img_sel_t frame_o
);

	// Five extra bits give 32 steps per move
	localparam int CNT_W = WALK_DELAY + 5;

	vga_pkg::move_state_t state_q;
	vga_pkg::move_state_t state_d;
	logic [CNT_W-1:0]     cnt_q;
	logic [CNT_W-1:0]     cnt_d;
	vga_pkg::coord_t      row_q;
	logic                 moving;
	logic                 step;

	assign moving = (state_q == vga_pkg::MOVE_UP) || (state_q == vga_pkg::MOVE_DOWN);
	assign step   = moving && (cnt_q[WALK_DELAY-1:0] == '0);

	////////////////////////////////////////////////////////////////////////////
	// State and step counter
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		cnt_d   = cnt_q;
		case (state_q)
			vga_pkg::MOVE_STOP: begin
				// Up wins when both are held
				if (up_i) begin
					state_d = vga_pkg::MOVE_UP;
					cnt_d   = '1;
				end else if (down_i) begin
					state_d = vga_pkg::MOVE_DOWN;
					cnt_d   = '1;
				end
			end
			vga_pkg::MOVE_UP, vga_pkg::MOVE_DOWN: begin
				if (cnt_q == '0)
					state_d = vga_pkg::MOVE_STOP;
				else
					cnt_d = cnt_q - 1'b1;
			end
			default: begin
				state_d = vga_pkg::MOVE_STOP;
				cnt_d   = '0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= vga_pkg::MOVE_STOP;
			cnt_q   <= '0;
			row_q   <= vga_pkg::coord_t'(vga_pkg::PLAYER_ROW_INIT);
		end else if (tick_i) begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			if (step) begin
				if (state_q == vga_pkg::MOVE_UP)
					row_q <= row_q - 1'b1;
				else
					row_q <= row_q + 1'b1;
			end
		end
	end

	assign row_o = row_q;
	// No horizontal movement in this level
	assign col_o = vga_pkg::coord_t'(vga_pkg::PLAYER_COL_INIT);

	// Walking frames alternate only while moving up
	always_comb begin
		frame_o = vga_pkg::IMG_FRONT;
		if (state_q == vga_pkg::MOVE_UP)
			frame_o = cnt_q[WALK_DELAY+3] ? vga_pkg::IMG_UP1 : vga_pkg::IMG_UP0;
	end

endmodule

`default_nettype wire

//--- pixel_image.sv
// Image memory of 12-bit pixels
// One synchronous write port and one registered read port

`timescale 1ns/1ps
`default_nettype none

module pixel_image #(
	parameter int DEPTH = 1024
) (
	input  logic               clk,
	input  logic               we_i,
	input  vga_pkg::img_addr_t waddr_i,
	input  vga_pkg::img_addr_t raddr_i,
	input  vga_pkg::rgb_t      wdata_i,
	output vga_pkg::rgb_t      rdata_o
);

	localparam int AW = $clog2(DEPTH);

	vga_pkg::rgb_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we_i)
			mem[waddr_i[AW-1:0]] <= wdata_i;
		rdata_o <= mem[raddr_i[AW-1:0]];
	end

endmodule

`default_nettype wire

//--- scene_render.sv
// Scene renderer
// Tile map background with a keyed double size sprite, two stage pipeline

`timescale 1ns/1ps
`default_nettype none

module scene_render (
	input  logic               clk,
	input  logic               rst,
	input  logic               sw_map_i,
	vga_timing_if.sink         tim,
	input  vga_pkg::coord_t    player_row_i,
	input  vga_pkg::coord_t    player_col_i,
	input  vga_pkg::img_sel_t  frame_i,
	input  vga_pkg::img_sel_t  img_sel_i,
	input  logic               img_we_i,
	input  vga_pkg::img_addr_t img_addr_i,
	input  vga_pkg::rgb_t      img_data_i,
	output vga_pkg::rgb_t      rgb_o,
	output logic               hsync_o,
	output logic               vsync_o
);

	localparam int MAP_WORDS   = vga_pkg::MAP_ROWS * vga_pkg::MAP_COLS;
	localparam int SPR_BITS    = $clog2(vga_pkg::SPRITE_SIZE);
	localparam int SPR_DEPTH   = vga_pkg::SPRITE_SIZE * vga_pkg::SPRITE_SIZE;
	localparam int ATLAS_DEPTH = 4 * vga_pkg::TILE_SIZE * vga_pkg::TILE_SIZE;

	vga_pkg::tile_code_t tile_map [MAP_WORDS];

	logic                map_loaded;
	vga_pkg::coord_t     half_h;
	vga_pkg::coord_t     half_v;
	vga_pkg::coord_t     col_raw;
	vga_pkg::coord_t     row_raw;
	logic [4:0]          tile_col;
	logic [4:0]          tile_row;
	logic [7:0]          tile_idx;
	vga_pkg::tile_code_t tile_code;
	logic                in_map;
	vga_pkg::img_addr_t  atlas_addr;
	logic [10:0]         win_bottom;
	logic [10:0]         win_right;
	logic                sprite_en;
	vga_pkg::coord_t     dv;
	vga_pkg::coord_t     dh;
	vga_pkg::img_addr_t  sprite_addr;
	logic [3:0]          img_we;
	vga_pkg::rgb_t       front_pix;
	vga_pkg::rgb_t       up0_pix;
	vga_pkg::rgb_t       up1_pix;
	vga_pkg::rgb_t       atlas_pix;
	vga_pkg::rgb_t       sprite_pix;
	vga_pkg::rgb_t       pix_d;
	logic                active_q;
	logic                sprite_en_q;
	vga_pkg::img_sel_t   frame_q;
	logic                hsync_q;
	logic                vsync_q;

	initial $readmemh("tile_map.hex", tile_map);

	// Stays set once the switch has been seen
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			map_loaded <= 1'b0;
		else if (sw_map_i)
			map_loaded <= 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Background at half resolution
	////////////////////////////////////////////////////////////////////////////

	assign half_h  = tim.h_pos >> 1;
	assign half_v  = tim.v_pos >> 1;
	assign col_raw = vga_pkg::coord_t'(half_h / vga_pkg::TILE_SIZE);
	assign row_raw = vga_pkg::coord_t'(half_v / vga_pkg::TILE_SIZE);

	// Clamp to the last map column and row
	assign tile_col = (int'(col_raw) < vga_pkg::MAP_COLS) ? col_raw[4:0] :
	                  5'(vga_pkg::MAP_COLS - 1);
	assign tile_row = (int'(row_raw) < vga_pkg::MAP_ROWS) ? row_raw[4:0] :
	                  5'(vga_pkg::MAP_ROWS - 1);
	assign tile_idx  = 8'(int'(tile_row) * vga_pkg::MAP_COLS + int'(tile_col));
	assign tile_code = tile_map[tile_idx];

	assign in_map = (int'(half_h) < vga_pkg::MAP_COLS * vga_pkg::TILE_SIZE) &&
	                (int'(half_v) < vga_pkg::MAP_ROWS * vga_pkg::TILE_SIZE);

	// Code bit 1 selects the lower quadrant row, bit 0 the right one
	assign atlas_addr = (map_loaded && in_map && !tile_code[2]) ?
	                    {tile_code[1], half_v[3:0], tile_code[0], half_h[3:0]} : '0;

	////////////////////////////////////////////////////////////////////////////
	// Sprite window, half open
	////////////////////////////////////////////////////////////////////////////

	assign win_bottom = {1'b0, player_row_i} + 11'(vga_pkg::SPRITE_LEN);
	assign win_right  = {1'b0, player_col_i} + 11'(vga_pkg::SPRITE_LEN);
	assign sprite_en  = (tim.v_pos >= player_row_i) && ({1'b0, tim.v_pos} < win_bottom) &&
	                    (tim.h_pos >= player_col_i) && ({1'b0, tim.h_pos} < win_right);

	assign dv = tim.v_pos - player_row_i;
	assign dh = tim.h_pos - player_col_i;
	// Row times sprite width plus column, each halved
	assign sprite_addr = sprite_en ?
	                     vga_pkg::img_addr_t'({dv[SPR_BITS:1], dh[SPR_BITS:1]}) : '0;

	////////////////////////////////////////////////////////////////////////////
	// Image memories
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < 4; i++)
			img_we[i] = img_we_i && (int'(img_sel_i) == i);
	end

	pixel_image #(.DEPTH(SPR_DEPTH)) u_front (
		.clk     (clk),
		.we_i    (img_we[vga_pkg::IMG_FRONT]),
		.waddr_i (img_addr_i),
		.raddr_i (sprite_addr),
		.wdata_i (img_data_i),
		.rdata_o (front_pix)
	);

	pixel_image #(.DEPTH(SPR_DEPTH)) u_up0 (
		.clk     (clk),
		.we_i    (img_we[vga_pkg::IMG_UP0]),
		.waddr_i (img_addr_i),
		.raddr_i (sprite_addr),
		.wdata_i (img_data_i),
		.rdata_o (up0_pix)
	);

	pixel_image #(.DEPTH(SPR_DEPTH)) u_up1 (
		.clk     (clk),
		.we_i    (img_we[vga_pkg::IMG_UP1]),
		.waddr_i (img_addr_i),
		.raddr_i (sprite_addr),
		.wdata_i (img_data_i),
		.rdata_o (up1_pix)
	);

	pixel_image #(.DEPTH(ATLAS_DEPTH)) u_atlas (
		.clk     (clk),
		.we_i    (img_we[vga_pkg::IMG_ATLAS]),
		.waddr_i (img_addr_i),
		.raddr_i (atlas_addr),
		.wdata_i (img_data_i),
		.rdata_o (atlas_pix)
	);

	////////////////////////////////////////////////////////////////////////////
	// Pipeline alignment and compositing
	////////////////////////////////////////////////////////////////////////////

	// Stage 1 travels alongside the memory read
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active_q    <= 1'b0;
			sprite_en_q <= 1'b0;
			frame_q     <= vga_pkg::IMG_FRONT;
			hsync_q     <= 1'b1;
			vsync_q     <= 1'b1;
		end else begin
			active_q    <= tim.active;
			sprite_en_q <= sprite_en;
			frame_q     <= frame_i;
			hsync_q     <= tim.hsync_raw;
			vsync_q     <= tim.vsync_raw;
		end
	end

	always_comb begin
		case (frame_q)
			vga_pkg::IMG_UP0: sprite_pix = up0_pix;
			vga_pkg::IMG_UP1: sprite_pix = up1_pix;
			default:          sprite_pix = front_pix;
		endcase
		if (!active_q)
			pix_d = '0;
		else if (sprite_en_q && (sprite_pix != vga_pkg::TRANSPARENT_KEY))
			pix_d = sprite_pix;
		else
			pix_d = atlas_pix;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb_o   <= '0;
			hsync_o <= 1'b1;
			vsync_o <= 1'b1;
		end else begin
			rgb_o   <= pix_d;
			hsync_o <= hsync_q;
			vsync_o <= vsync_q;
		end
	end

endmodule

`default_nettype wire

//--- game_top.sv
// Top level of the VGA tile game
// Timing, buttons, player motion and the scene renderer on one pixel clock

`timescale 1ns/1ps
`default_nettype none

module game_top #(
	parameter int TICK_LOG2  = 13,
	parameter int WALK_DELAY = 6
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               btn_up_i,
	input  logic               btn_down_i,
	input  logic               sw_map_i,
	input  logic               img_we_i,
	input  vga_pkg::img_sel_t  img_sel_i,
	input  vga_pkg::img_addr_t img_addr_i,
	input  vga_pkg::rgb_t      img_data_i,
	output vga_pkg::rgb_t      rgb_o,
	output logic               hsync_o,
	output logic               vsync_o
);

	logic              tick;
	logic              up_pressed;
	logic              down_pressed;
	vga_pkg::coord_t   player_row;
	vga_pkg::coord_t   player_col;
	vga_pkg::img_sel_t frame;

	vga_timing_if tim ();

	vga_timing u_timing (
		.clk (clk),
		.rst (rst),
		.tim (tim)
	);

	button_input #(.TICK_LOG2(TICK_LOG2)) u_buttons (
		.clk        (clk),
		.rst        (rst),
		.btn_up_i   (btn_up_i),
		.btn_down_i (btn_down_i),
		.tick_o     (tick),
		.up_o       (up_pressed),
		.down_o     (down_pressed)
	);

	player_motion #(.WALK_DELAY(WALK_DELAY)) u_motion (
		.clk     (clk),
		.rst     (rst),
		.tick_i  (tick),
		.up_i    (up_pressed),
		.down_i  (down_pressed),
		.row_o   (player_row),
		.col_o   (player_col),
		.frame_o (frame)
	);

	scene_render u_render (
		.clk          (clk),
		.rst          (rst),
		.sw_map_i     (sw_map_i),
		.tim          (tim),
		.player_row_i (player_row),
		.player_col_i (player_col),
		.frame_i      (frame),
		.img_sel_i    (img_sel_i),
		.img_we_i     (img_we_i),
		.img_addr_i   (img_addr_i),
		.img_data_i   (img_data_i),
		.rgb_o        (rgb_o),
		.hsync_o      (hsync_o),
		.vsync_o      (vsync_o)
	);

endmodule

`default_nettype wire

//--- game_checker.sv
// Assertions on the VGA outputs of the game top level
// Sync pulse widths and black output while a sync pulse is low

`timescale 1ns/1ps
`default_nettype none

module game_checker (
	input logic          clk,
	input logic          rst,
	input logic          hsync_i,
	input logic          vsync_i,
	input vga_pkg::rgb_t rgb_i
);

	// Length of the current low phase of each sync
	logic [7:0]  hs_low;
	logic [11:0] vs_low;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hs_low <= '0;
			vs_low <= '0;
		end else begin
			hs_low <= hsync_i ? '0 : hs_low + 1'b1;
			vs_low <= vsync_i ? '0 : vs_low + 1'b1;
		end
	end

	hsync_width: assert property (@(posedge clk) disable iff (rst)
		$rose(hsync_i) |-> (int'(hs_low) == vga_pkg::H_SYNC))
		else $error("hsync_o was low for %0d cycles", hs_low);

	// Two whole lines of pixel clocks
	vsync_width: assert property (@(posedge clk) disable iff (rst)
		$rose(vsync_i) |-> (int'(vs_low) == vga_pkg::V_SYNC * vga_pkg::H_TOTAL))
		else $error("vsync_o was low for %0d cycles", vs_low);

	sync_black: assert property (@(posedge clk) disable iff (rst)
		(!hsync_i || !vsync_i) |-> (rgb_i == '0))
		else $error("rgb_o is %h inside a sync pulse", rgb_i);

endmodule

bind game_top game_checker u_checker (
	.clk     (clk),
	.rst     (rst),
	.hsync_i (hsync_o),
	.vsync_i (vsync_o),
	.rgb_i   (rgb_o)
);

`default_nettype wire

//--- tb_game_top.sv
// Testbench of the VGA tile game top level
// Cycle model of timing, buttons and motion, compared with rgb_o and the syncs

`timescale 1ns/1ps
`default_nettype none

module tb_game_top;

	localparam int TICK_LOG2   = 2;
	localparam int WALK_DELAY  = 6;
	localparam int LINE_CYC    = vga_pkg::H_TOTAL;
	localparam int FRAME_CYC   = vga_pkg::H_TOTAL * vga_pkg::V_TOTAL;
	localparam int RUN_FRAMES  = 6;
	localparam int CYCLE_LIMIT = RUN_FRAMES * FRAME_CYC + 20000;
	localparam int HOLD_CYC    = 10 * (1 << TICK_LOG2);
	localparam int CNT_MAX     = (1 << (WALK_DELAY + 5)) - 1;
	localparam int HS_START    = vga_pkg::H_DISPLAY + vga_pkg::H_FRONT;
	localparam int HS_END      = HS_START + vga_pkg::H_SYNC;
	localparam int VS_START    = vga_pkg::V_DISPLAY + vga_pkg::V_FRONT;
	localparam int VS_END      = VS_START + vga_pkg::V_SYNC;
	localparam int MAX_REPORTS = 20;

	logic               clk = 1'b0;
	logic               rst = 1'b1;
	logic               btn_up_i;
	logic               btn_down_i;
	logic               sw_map_i;
	logic               img_we_i;
	vga_pkg::img_sel_t  img_sel_i;
	vga_pkg::img_addr_t img_addr_i;
	vga_pkg::rgb_t      img_data_i;
	vga_pkg::rgb_t      rgb_o;
	logic               hsync_o;
	logic               vsync_o;

	// Copies of the loaded art and the level
	vga_pkg::rgb_t       sprite_mem [3][256];
	vga_pkg::rgb_t       atlas_mem [1024];
	vga_pkg::tile_code_t map_mem [200];
	integer              seed;
	logic                load_done;

	// Reference model state, valid for the current cycle
	int                   m_cyc;
	int                   m_pix;
	int                   m_line;
	int                   m_div;
	logic                 m_hraw;
	logic                 m_vraw;
	logic                 m_map;
	logic [4:0]           m_up_sh;
	logic [4:0]           m_down_sh;
	vga_pkg::move_state_t m_state;
	int                   m_cnt;
	int                   m_row;

	// Predictions waiting for the two output stages
	vga_pkg::rgb_t rgb_p1;
	vga_pkg::rgb_t rgb_p2;
	logic          rgb_v1;
	logic          rgb_v2;
	logic          hs_p1;
	logic          hs_p2;
	logic          vs_p1;
	logic          vs_p2;

	int err_rgb = 0;
	int err_sync = 0;
	int n_rgb = 0;
	int n_sync = 0;
	int stim_cycle;

	game_top #(
		.TICK_LOG2  (TICK_LOG2),
		.WALK_DELAY (WALK_DELAY)
	) uut (
		.clk        (clk),
		.rst        (rst),
		.btn_up_i   (btn_up_i),
		.btn_down_i (btn_down_i),
		.sw_map_i   (sw_map_i),
		.img_we_i   (img_we_i),
		.img_sel_i  (img_sel_i),
		.img_addr_i (img_addr_i),
		.img_data_i (img_data_i),
		.rgb_o      (rgb_o),
		.hsync_o    (hsync_o),
		.vsync_o    (vsync_o)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////////////////////////////////////////

	function automatic vga_pkg::img_sel_t frame_of(input vga_pkg::move_state_t state,
		input int cnt);
		if (state != vga_pkg::MOVE_UP)
			return vga_pkg::IMG_FRONT;
		return ((cnt >> (WALK_DELAY + 3)) % 2 == 1) ? vga_pkg::IMG_UP1 : vga_pkg::IMG_UP0;
	endfunction

	function automatic vga_pkg::rgb_t expected_rgb(input int h, input int v, input logic act,
		input logic map_on, input int row, input vga_pkg::img_sel_t frame);
		int            hh;
		int            hv;
		int            code;
		int            bg_addr;
		int            spr_addr;
		int            col;
		vga_pkg::rgb_t spr;
		if (!act)
			return '0;
		hh      = h / 2;
		hv      = v / 2;
		col     = vga_pkg::PLAYER_COL_INIT;
		bg_addr = 0;
		if (map_on && hh < 320 && hv < 160) begin
			code = int'(map_mem[(hv / 16) * vga_pkg::MAP_COLS + hh / 16]);
			// Odd codes take the right quadrant, 2 and 3 the lower one
			if (code < 4)
				bg_addr = (hv % 16 + ((code >= 2) ? 16 : 0)) * 32 + hh % 16 + (code % 2) * 16;
		end
		if (v >= row && v < row + 32 && h >= col && h < col + 32) begin
			spr_addr = ((v - row) / 2) * 16 + (h - col) / 2;
			spr      = sprite_mem[frame][spr_addr];
			if (spr != vga_pkg::TRANSPARENT_KEY)
				return spr;
		end
		return atlas_mem[bg_addr];
	endfunction

	// One move step per tick, 32 rows per press
	task automatic advance_motion(input logic up_deb, input logic down_deb);
		if (m_state == vga_pkg::MOVE_STOP) begin
			if (up_deb) begin
				m_state = vga_pkg::MOVE_UP;
				m_cnt   = CNT_MAX;
			end else if (down_deb) begin
				m_state = vga_pkg::MOVE_DOWN;
				m_cnt   = CNT_MAX;
			end
		end else begin
			if (m_cnt % (1 << WALK_DELAY) == 0)
				m_row = (m_state == vga_pkg::MOVE_UP) ? m_row - 1 : m_row + 1;
			if (m_cnt == 0)
				m_state = vga_pkg::MOVE_STOP;
			else
				m_cnt = m_cnt - 1;
		end
	endtask

	task automatic check_rgb(input vga_pkg::rgb_t got, input vga_pkg::rgb_t exp);
		n_rgb++;
		if (got !== exp) begin
			err_rgb++;
			if (err_rgb + err_sync <= MAX_REPORTS)
				$display("[FAIL] %0d ns: rgb_o is %h, expected %h (cycle %0d)",
				         $time, got, exp, m_cyc);
		end
	endtask

	task automatic check_sync(input logic got, input logic exp, input string name);
		n_sync++;
		if (got !== exp) begin
			err_sync++;
			if (err_rgb + err_sync <= MAX_REPORTS)
				$display("[FAIL] %0d ns: %s is %b, expected %b (cycle %0d)",
				         $time, name, got, exp, m_cyc);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Model and compare, mid cycle where outputs are stable
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		logic tick;
		logic up_deb;
		logic down_deb;
		logic act;
		if (rst) begin
			m_cyc     = 0;
			m_pix     = 0;
			m_line    = 0;
			m_div     = 0;
			m_hraw    = 1'b1;
			m_vraw    = 1'b1;
			m_map     = 1'b0;
			m_up_sh   = '0;
			m_down_sh = '0;
			m_state   = vga_pkg::MOVE_STOP;
			m_cnt     = 0;
			m_row     = vga_pkg::PLAYER_ROW_INIT;
			rgb_p1    = '0;
			rgb_p2    = '0;
			rgb_v1    = 1'b1;
			rgb_v2    = 1'b1;
			hs_p1     = 1'b1;
			hs_p2     = 1'b1;
			vs_p1     = 1'b1;
			vs_p2     = 1'b1;
		end else begin
			if (rgb_v2)
				check_rgb(rgb_o, rgb_p2);
			check_sync(hsync_o, hs_p2, "hsync_o");
			check_sync(vsync_o, vs_p2, "vsync_o");

			act    = (m_pix < vga_pkg::H_DISPLAY) && (m_line < vga_pkg::V_DISPLAY);
			rgb_p2 = rgb_p1;
			rgb_v2 = rgb_v1;
			rgb_p1 = expected_rgb(m_pix, m_line, act, m_map, m_row, frame_of(m_state, m_cnt));
			// Reads that race the image load are not predicted
			rgb_v1 = load_done && !img_we_i;
			hs_p2  = hs_p1;
			hs_p1  = m_hraw;
			vs_p2  = vs_p1;
			vs_p1  = m_vraw;

			m_hraw = !(m_pix >= HS_START && m_pix < HS_END);
			m_vraw = !(m_line >= VS_START && m_line < VS_END);
			if (m_pix == vga_pkg::H_TOTAL - 1) begin
				m_pix  = 0;
				m_line = (m_line == vga_pkg::V_TOTAL - 1) ? 0 : m_line + 1;
			end else begin
				m_pix = m_pix + 1;
			end
			m_map = m_map | sw_map_i;

			tick  = (m_div == (1 << TICK_LOG2) - 1);
			m_div = (m_div + 1) % (1 << TICK_LOG2);
			if (tick) begin
				up_deb    = &m_up_sh;
				down_deb  = &m_down_sh;
				m_up_sh   = {m_up_sh[3:0], btn_up_i};
				m_down_sh = {m_down_sh[3:0], btn_down_i};
				advance_motion(up_deb, down_deb);
			end

			m_cyc = m_cyc + 1;
			if (m_cyc >= CYCLE_LIMIT) begin
				$display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
				$display("Test failed");
				$finish;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Image load, starts during reset
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int            depth;
		vga_pkg::rgb_t word;
		img_we_i   = 1'b0;
		img_sel_i  = vga_pkg::IMG_FRONT;
		img_addr_i = '0;
		img_data_i = '0;
		load_done  = 1'b0;
		seed       = 32'h9d86;
		$readmemh("tile_map.hex", map_mem);
		for (int sel = 0; sel < 4; sel++) begin
			depth = (sel == 3) ? 1024 : 256;
			for (int a = 0; a < depth; a++) begin
				word = vga_pkg::rgb_t'($random(seed));
				// Diagonal of each sprite image is see-through
				if (sel < 3 && (a % 16) == (a / 16))
					word = vga_pkg::TRANSPARENT_KEY;
				if (sel == 3)
					atlas_mem[a] = word;
				else
					sprite_mem[sel][a] = word;
				@(posedge clk);
				#2;
				img_we_i   = 1'b1;
				img_sel_i  = vga_pkg::img_sel_t'(sel);
				img_addr_i = vga_pkg::img_addr_t'(a);
				img_data_i = word;
			end
		end
		@(posedge clk);
		#2;
		img_we_i  = 1'b0;
		load_done = 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic advance_to(input int target);
		while (stim_cycle < target) begin
			@(posedge clk);
			stim_cycle++;
		end
		#2;
	endtask

	initial begin
		btn_up_i   = 1'b0;
		btn_down_i = 1'b0;
		sw_map_i   = 1'b0;
		stim_cycle = 0;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		// Frame 1 turns the map on
		advance_to(FRAME_CYC + 100 * LINE_CYC);
		sw_map_i = 1'b1;
		advance_to(stim_cycle + 1);
		sw_map_i = 1'b0;

		// Frame 2 walks up while the sprite rows are scanned
		advance_to(2 * FRAME_CYC + 280 * LINE_CYC);
		btn_up_i = 1'b1;
		advance_to(stim_cycle + HOLD_CYC);
		btn_up_i = 1'b0;

		// Frame 4 walks down, second press lands mid move
		advance_to(4 * FRAME_CYC + 280 * LINE_CYC);
		btn_down_i = 1'b1;
		advance_to(stim_cycle + HOLD_CYC);
		btn_down_i = 1'b0;
		advance_to(4 * FRAME_CYC + 285 * LINE_CYC);
		btn_down_i = 1'b1;
		advance_to(stim_cycle + HOLD_CYC);
		btn_down_i = 1'b0;

		advance_to(RUN_FRAMES * FRAME_CYC);
		$display("Checked %0d pixels and %0d sync samples: %0d rgb errors, %0d sync errors",
		         n_rgb, n_sync, err_rgb, err_sync);
		if (err_rgb == 0 && err_sync == 0 && n_rgb > 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tile_map.hex
// Level tile codes, one map row per line, 20 columns from left to right
// Codes 0 to 3 pick an atlas quadrant, 4 and above show atlas word 0
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
1 0 2 2 0 0 0 0 3 3 3 0 0 0 0 2 2 0 0 1
1 0 0 0 0 4 4 0 0 0 0 0 0 5 0 0 0 0 0 1
1 0 0 0 0 0 0 0 0 2 2 0 0 0 0 0 0 0 0 1
1 0 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 0 1
1 0 0 0 0 2 2 2 0 0 0 0 2 2 2 0 0 0 0 1
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
1 0 0 6 0 0 0 0 0 0 0 0 0 0 0 0 7 0 0 1
3 3 3 3 3 3 3 3 3 3 3 3 3 3 3 3 3 3 3 3

//--- files.f
vga_pkg.sv
vga_timing_if.sv
vga_timing.sv
button_input.sv
player_motion.sv
pixel_image.sv
scene_render.sv
game_top.sv
game_checker.sv
tb_game_top.sv

//--- Makefile
TOP := tb_game_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Test failed" >> sim.log
	cat sim.log
	! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log
